/* verilog/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

  localparam int XLEN    = 16;
  localparam int PC_W    = 6;
  localparam int INSTR_W = 16;
  localparam int REG_N   = 8;
  localparam int REG_W   = $clog2(REG_N);
  localparam int OPC_W   = 4;
  localparam int IMM_W   = INSTR_W - OPC_W - 2 * REG_W;

  // Codes outside this list decode as OP_NOP
  typedef enum logic [OPC_W-1:0] {
    OP_NOP  = 4'd0,
    OP_LI   = 4'd1,
    OP_ADD  = 4'd2,
    OP_ADDI = 4'd3,
    OP_MUL  = 4'd4,
    OP_BNEZ = 4'd5
  } opcode_e;

  typedef enum logic {
    ST_IDLE,
    ST_MUL
  } exec_state_e;

  // Raw instruction word, opcode in the top bits
  typedef struct packed {
    logic [OPC_W-1:0] op;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs;
    logic [IMM_W-1:0] imm;
  } instr_t;

  typedef struct packed {
    logic [PC_W-1:0] pc;
    instr_t          instr;
  } fetch_pkt_t;

  typedef struct packed {
    logic [PC_W-1:0]  pc;
    opcode_e          op;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs;
    logic [XLEN-1:0]  imm;
  } dec_pkt_t;

  typedef struct packed {
    logic [PC_W-1:0]  pc;
    opcode_e          op;
    logic             we;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  data;
  } retire_t;

  typedef struct packed {
    logic            valid;
    logic [PC_W-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

/* verilog/pipe_ctrl.sv */
`default_nettype none

module pipe_ctrl #(
  parameter int REG = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  input  logic ready_i,
  input  logic stall_i,
  input  logic flush_i,
  input  logic bubble_i,
  output logic valid_o,
  output logic advance_o,
  output logic flush_o,
  output logic bubble_o
);

  generate
    if (REG != 0) begin : g_reg
      logic valid_q;
      logic can_accept;
      logic hold;

      assign can_accept = !valid_q || ready_i;
      assign hold       = stall_i || !can_accept;

      // Flush wins over stall and back-pressure
      always_comb begin
        advance_o = 1'b0;
        flush_o   = 1'b0;
        bubble_o  = 1'b0;
        if (flush_i) begin
          flush_o = 1'b1;
        end else if (!hold) begin
          if (bubble_i) begin
            bubble_o = 1'b1;
          end else if (valid_i) begin
            advance_o = 1'b1;
          end
        end
      end

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          valid_q <= 1'b0;
        end else if (flush_o || bubble_o) begin
          valid_q <= 1'b0;
        end else if (!hold) begin
          valid_q <= valid_i;
        end
      end

      assign valid_o = valid_q;
    end else begin : g_pass
      // Combinational stage, nothing is held here
      assign valid_o   = valid_i;
      assign advance_o = 1'b1;
      assign flush_o   = 1'b0;
      assign bubble_o  = 1'b0;
    end
  endgenerate

  a_one_action: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({advance_o, flush_o, bubble_o}))
    else $error("pipe_ctrl: more than one action in a cycle");

  a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
    flush_o |=> !valid_o)
    else $error("pipe_ctrl: stage still valid after flush");

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`default_nettype none

module fetch_unit
  import rv_pipe_pkg::*;
#(
  parameter int FETCH_REG = 1
) (
  input  logic               clk,
  input  logic               rst_n,
  output logic [PC_W-1:0]    imem_addr_o,
  input  logic [INSTR_W-1:0] imem_data_i,
  input  redirect_t          redirect_i,
  input  logic               accept_i,
  output logic               valid_o,
  output fetch_pkt_t         pkt_o
);

  logic [PC_W-1:0] pc;
  fetch_pkt_t      cur_pkt;
  logic            advance;
  logic            step;

  assign imem_addr_o   = pc;
  assign cur_pkt.pc    = pc;
  assign cur_pkt.instr = instr_t'(imem_data_i);

  // The word read on a redirect cycle is on the wrong path
  pipe_ctrl #(
    .REG(FETCH_REG)
  ) i_pipe_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (!redirect_i.valid),
    .ready_i  (accept_i),
    .stall_i  (1'b0),
    .flush_i  (redirect_i.valid),
    .bubble_i (1'b0),
    .valid_o  (valid_o),
    .advance_o(advance),
    .flush_o  (),
    .bubble_o ()
  );

  // Registered slot takes the word at pc, passthrough needs decode to take it
  assign step = advance && ((FETCH_REG != 0) || (valid_o && accept_i));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (redirect_i.valid) begin
      pc <= redirect_i.target;
    end else if (step) begin
      pc <= pc + 1'b1;
    end
  end

  generate
    if (FETCH_REG != 0) begin : g_slot
      fetch_pkt_t slot;

      always_ff @(posedge clk) begin
        if (advance) begin
          slot <= cur_pkt;
        end
      end

      assign pkt_o = slot;
    end else begin : g_direct
      assign pkt_o = cur_pkt;
    end
  endgenerate

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`default_nettype none

module decode_stage
  import rv_pipe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid_i,
  input  fetch_pkt_t pkt_i,
  input  logic       halt_i,
  input  logic       pause_i,
  input  logic       flush_i,
  input  logic       ready_i,
  output logic       accept_o,
  output logic       valid_o,
  output dec_pkt_t   pkt_o
);

  logic     stage_valid;
  opcode_e  dec_op;
  dec_pkt_t dec_pkt;

  pipe_ctrl #(
    .REG(1)
  ) i_pipe_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (valid_i),
    .ready_i  (ready_i),
    .stall_i  (halt_i),
    .flush_i  (flush_i),
    .bubble_i (pause_i),
    .valid_o  (stage_valid),
    .advance_o(accept_o),
    .flush_o  (),
    .bubble_o ()
  );

  always_comb begin
    case (pkt_i.instr.op)
      OP_LI, OP_ADD, OP_ADDI, OP_MUL, OP_BNEZ: dec_op = opcode_e'(pkt_i.instr.op);
      default:                                 dec_op = OP_NOP;
    endcase
  end

  assign dec_pkt.pc  = pkt_i.pc;
  assign dec_pkt.op  = dec_op;
  assign dec_pkt.rd  = pkt_i.instr.rd;
  assign dec_pkt.rs  = pkt_i.instr.rs;
  assign dec_pkt.imm = {{(XLEN - IMM_W){pkt_i.instr.imm[IMM_W-1]}}, pkt_i.instr.imm};

  always_ff @(posedge clk) begin
    if (accept_o) begin
      pkt_o <= dec_pkt;
    end
  end

  // A frozen stage must not hand the same instruction to execute twice
  assign valid_o = stage_valid && !halt_i;

  // Held means frozen by halt or waiting on execute
  a_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (stage_valid && (halt_i || !ready_i)) |=> $stable(pkt_o))
    else $error("decode_stage: payload changed while held");

endmodule

`default_nettype wire

/* verilog/exec_stage.sv */
`default_nettype none

module exec_stage
  import rv_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      valid_i,
  input  dec_pkt_t  pkt_i,
  input  logic      retire_ready_i,
  output logic      ready_o,
  output redirect_t redirect_o,
  output logic      retire_valid_o,
  output retire_t   retire_o
);

  localparam int CNT_W = $clog2(XLEN);

  logic [XLEN-1:0] rf [REG_N];

  exec_state_e     state;
  logic            ex_valid;
  dec_pkt_t        ex_pkt;

  // Shift-add multiplier
  logic [XLEN-1:0] mul_a;
  logic [XLEN-1:0] mul_b;
  logic [XLEN-1:0] mul_acc;
  logic [CNT_W-1:0] mul_cnt;
  logic [XLEN-1:0] mul_sum;
  logic            mul_last;

  logic [XLEN-1:0] rd_val;
  logic [XLEN-1:0] rs_val;
  logic [XLEN-1:0] result;
  logic            wen;
  logic            taken;
  logic [PC_W-1:0] target;
  logic            retire_free;
  logic            done;
  retire_t         retire_next;

  assign rd_val      = rf[ex_pkt.rd];
  assign rs_val      = rf[ex_pkt.rs];
  assign mul_sum     = mul_acc + (mul_b[0] ? mul_a : '0);
  assign mul_last    = (state == ST_MUL) && (mul_cnt == CNT_W'(XLEN - 1));
  assign retire_free = !retire_valid_o || retire_ready_i;
  assign target      = ex_pkt.pc + ex_pkt.imm[PC_W-1:0];

  always_comb begin
    result = '0;
    wen    = 1'b0;
    taken  = 1'b0;
    case (ex_pkt.op)
      OP_LI: begin
        result = ex_pkt.imm;
        wen    = 1'b1;
      end
      OP_ADD: begin
        result = rd_val + rs_val;
        wen    = 1'b1;
      end
      OP_ADDI: begin
        result = rd_val + ex_pkt.imm;
        wen    = 1'b1;
      end
      OP_MUL: begin
        result = mul_sum;
        wen    = 1'b1;
      end
      OP_BNEZ: taken = (rs_val != '0);
      default: ;
    endcase
  end

  // MUL completes on its last shift step, the rest in their first cycle
  assign done = ex_valid && retire_free && ((ex_pkt.op != OP_MUL) || mul_last);

  // No new instruction while a taken branch retires or its redirect is out
  assign ready_o = (!ex_valid || done) && !(done && taken) && !redirect_o.valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid       <= 1'b0;
      state          <= ST_IDLE;
      retire_valid_o <= 1'b0;
      redirect_o     <= '0;
    end else begin
      if (ready_o) begin
        ex_valid <= valid_i;
      end else if (done) begin
        ex_valid <= 1'b0;
      end

      case (state)
        ST_IDLE: begin
          if (ex_valid && (ex_pkt.op == OP_MUL)) begin
            state <= ST_MUL;
          end
        end
        ST_MUL: begin
          if (done) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase

      if (done) begin
        retire_valid_o <= 1'b1;
      end else if (retire_ready_i) begin
        retire_valid_o <= 1'b0;
      end

      redirect_o.valid  <= done && taken;
      redirect_o.target <= target;
    end
  end

  always_ff @(posedge clk) begin
    if (ready_o && valid_i) begin
      ex_pkt <= pkt_i;
    end
  end

  // Operands are latched when the multiply starts
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && ex_valid && (ex_pkt.op == OP_MUL)) begin
      mul_a   <= rd_val;
      mul_b   <= rs_val;
      mul_acc <= '0;
      mul_cnt <= '0;
    end else if ((state == ST_MUL) && !mul_last) begin
      mul_acc <= mul_sum;
      mul_a   <= mul_a << 1;
      mul_b   <= mul_b >> 1;
      mul_cnt <= mul_cnt + 1'b1;
    end
  end

  assign retire_next.pc   = ex_pkt.pc;
  assign retire_next.op   = ex_pkt.op;
  assign retire_next.we   = wen;
  assign retire_next.rd   = ex_pkt.rd;
  assign retire_next.data = result;

  always_ff @(posedge clk) begin
    if (done) begin
      retire_o <= retire_next;
      if (wen) begin
        rf[ex_pkt.rd] <= result;
      end
    end
  end

  a_retire_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (retire_valid_o && !retire_ready_i) |=> (retire_valid_o && $stable(retire_o)))
    else $error("exec_stage: retire changed under back-pressure");

  a_redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_o.valid |=> !redirect_o.valid)
    else $error("exec_stage: redirect valid on two cycles in a row");

endmodule

`default_nettype wire

/* verilog/rv_pipe_top.sv */
`default_nettype none

module rv_pipe_top
  import rv_pipe_pkg::*;
#(
  parameter int FETCH_REG = 1
) (
  input  logic               clk,
  input  logic               rst_n,
  output logic [PC_W-1:0]    imem_addr_o,
  input  logic [INSTR_W-1:0] imem_data_i,
  input  logic               halt_i,
  input  logic               pause_i,
  output logic               retire_valid_o,
  input  logic               retire_ready_i,
  output retire_t            retire_o
);

  logic       fetch_valid;
  fetch_pkt_t fetch_pkt;
  logic       dec_accept;
  logic       dec_valid;
  dec_pkt_t   dec_pkt;
  logic       exec_ready;
  redirect_t  redirect;

  fetch_unit #(
    .FETCH_REG(FETCH_REG)
  ) i_fetch_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr_o(imem_addr_o),
    .imem_data_i(imem_data_i),
    .redirect_i (redirect),
    .accept_i   (dec_accept),
    .valid_o    (fetch_valid),
    .pkt_o      (fetch_pkt)
  );

  decode_stage i_decode_stage (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (fetch_valid),
    .pkt_i   (fetch_pkt),
    .halt_i  (halt_i),
    .pause_i (pause_i),
    .flush_i (redirect.valid),
    .ready_i (exec_ready),
    .accept_o(dec_accept),
    .valid_o (dec_valid),
    .pkt_o   (dec_pkt)
  );

  exec_stage i_exec_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (dec_valid),
    .pkt_i         (dec_pkt),
    .retire_ready_i(retire_ready_i),
    .ready_o       (exec_ready),
    .redirect_o    (redirect),
    .retire_valid_o(retire_valid_o),
    .retire_o      (retire_o)
  );

endmodule

`default_nettype wire

/* bench/rv_pipe_tb.sv */
`default_nettype none

module rv_pipe_tb
  import rv_pipe_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FETCH_REG  = 1;
  localparam int RST_CYCLES = 10;
  localparam int TARGET     = 300;
  localparam int WIN_CYCLES = 40;
  localparam int HALT_AT    = 100;
  localparam int PAUSE_AT   = 200;
  localparam int PROG_N     = 1 << PC_W;
  localparam int WATCHDOG_CYCLES = RST_CYCLES + TARGET * (XLEN + 8) * 4 + 2 * WIN_CYCLES;

  logic               clk = 1'b0;
  logic               rst_n;
  logic [PC_W-1:0]    imem_addr;
  logic [INSTR_W-1:0] imem_data;
  logic               halt_i;
  logic               pause_i;
  logic               retire_valid;
  logic               retire_ready_i;
  retire_t            retire;

  logic [INSTR_W-1:0] prog [PROG_N];
  logic [31:0]        rng;

  // Architectural model state
  logic [XLEN-1:0]    model_rf [REG_N];
  logic [PC_W-1:0]    model_pc;

  int                 retire_count = 0;
  int                 win_edges    = 0;
  int                 win_retires  = 0;
  logic               held         = 1'b0;
  retire_t            held_val;
  retire_t            exp_ret;
  logic               halt_done    = 1'b0;
  logic               pause_done   = 1'b0;

  always #50 clk = ~clk;

  // Instruction memory answers in the same cycle
  assign imem_data = prog[imem_addr];

  rv_pipe_top #(
    .FETCH_REG(FETCH_REG)
  ) i_rv_pipe_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .imem_addr_o   (imem_addr),
    .imem_data_i   (imem_data),
    .halt_i        (halt_i),
    .pause_i       (pause_i),
    .retire_valid_o(retire_valid),
    .retire_ready_i(retire_ready_i),
    .retire_o      (retire)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [INSTR_W-1:0] encode_instr(input logic [3:0] op,
                                                      input logic [2:0] rd,
                                                      input logic [2:0] rs,
                                                      input logic [5:0] imm);
    return {op, rd, rs, imm};
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // First words load every register, the rest is a random mix
  task automatic build_program();
    logic [31:0] r;
    logic [2:0]  rd;
    logic [2:0]  rs;
    logic [5:0]  imm;
    for (int i = 0; i < PROG_N; i++) begin
      rng = xorshift32(rng);
      r   = rng;
      rd  = r[10:8];
      rs  = r[13:11];
      imm = r[19:14];
      if (i < REG_N) begin
        prog[i] = encode_instr(OP_LI, 3'(i), rs, imm);
      end else begin
        case (r[3:0])
          4'd0, 4'd1, 4'd2, 4'd3: prog[i] = encode_instr(OP_ADD, rd, rs, imm);
          4'd4, 4'd5, 4'd6, 4'd15: prog[i] = encode_instr(OP_ADDI, rd, rs, imm);
          4'd7, 4'd8: prog[i] = encode_instr(OP_MUL, rd, rs, imm);
          // Forward branches only, 2 to 9 words ahead
          4'd9, 4'd10: prog[i] = encode_instr(OP_BNEZ, rd, rs, 6'd2 + {3'd0, r[16:14]});
          4'd11, 4'd12: prog[i] = encode_instr(OP_LI, rd, rs, imm);
          4'd13: prog[i] = encode_instr(OP_NOP, rd, rs, imm);
          default: prog[i] = encode_instr(4'd6 + {1'b0, r[22:20]}, rd, rs, imm);
        endcase
      end
    end
  endtask

  // Executes the instruction at the model pc and returns its retirement
  function automatic retire_t ref_step();
    logic [INSTR_W-1:0] w;
    logic [2:0]         rd;
    logic [2:0]         rs;
    logic [XLEN-1:0]    imm;
    logic [PC_W-1:0]    next_pc;
    retire_t            r;
    w       = prog[model_pc];
    rd      = w[11:9];
    rs      = w[8:6];
    imm     = {{(XLEN - 6){w[5]}}, w[5:0]};
    next_pc = model_pc + 1'b1;
    r       = '0;
    r.pc    = model_pc;
    r.rd    = rd;
    case (w[15:12])
      OP_LI: begin
        r.op   = OP_LI;
        r.we   = 1'b1;
        r.data = imm;
      end
      OP_ADD: begin
        r.op   = OP_ADD;
        r.we   = 1'b1;
        r.data = model_rf[rd] + model_rf[rs];
      end
      OP_ADDI: begin
        r.op   = OP_ADDI;
        r.we   = 1'b1;
        r.data = model_rf[rd] + imm;
      end
      OP_MUL: begin
        r.op   = OP_MUL;
        r.we   = 1'b1;
        r.data = model_rf[rd] * model_rf[rs];
      end
      OP_BNEZ: begin
        r.op = OP_BNEZ;
        if (model_rf[rs] != '0) begin
          next_pc = model_pc + imm[PC_W-1:0];
        end
      end
      default: r.op = OP_NOP;
    endcase
    if (r.we) begin
      model_rf[rd] = r.data;
    end
    model_pc = next_pc;
    return r;
  endfunction

  // Compare at each rising edge, before the DUT's own flops update
  always @(posedge clk) begin
    if (rst_n) begin
      if (held) begin
        check_equal(32'(retire_valid), 32'd1, "retire valid dropped before accept");
        check_equal(32'(retire), 32'(held_val), "retire payload changed before accept");
      end
      if (retire_valid && retire_ready_i) begin
        if (retire_count == 0) begin
          check_equal(32'(retire.pc), 32'd0, "first retirement pc");
        end
        exp_ret = ref_step();
        check_equal(32'(retire.pc), 32'(exp_ret.pc), "retire pc");
        check_equal(32'(retire.op), 32'(exp_ret.op), "retire opcode");
        check_equal(32'(retire.we), 32'(exp_ret.we), "retire write enable");
        if (exp_ret.we) begin
          check_equal(32'(retire.rd), 32'(exp_ret.rd), "retire rd");
          check_equal(32'(retire.data), 32'(exp_ret.data), "retire data");
        end
        retire_count++;
        // Whatever sat in the retire register at window start is not counted
        if ((halt_i || pause_i) && (win_edges > 0)) begin
          win_retires++;
        end
      end
      if (halt_i || pause_i) begin
        check_equal(32'(win_retires <= 2), 32'd1, "retirements during halt or pause window");
        win_edges++;
      end else begin
        win_edges   = 0;
        win_retires = 0;
      end
      held     = retire_valid && !retire_ready_i;
      held_val = retire;
    end
  end

  // Stimulus, all inputs change on the falling edge
  initial begin
    rst_n          = 1'b0;
    halt_i         = 1'b0;
    pause_i        = 1'b0;
    retire_ready_i = 1'b0;
    model_pc       = '0;
    for (int i = 0; i < REG_N; i++) begin
      model_rf[i] = '0;
    end
    rng = 32'h6632_c47b;
    build_program();

    repeat (RST_CYCLES) @(negedge clk);
    check_equal(32'(retire_valid), 32'd0, "retire valid during reset");
    rst_n = 1'b1;

    while (retire_count < TARGET) begin
      @(negedge clk);
      if (!halt_done && (retire_count >= HALT_AT)) begin
        halt_i         = 1'b1;
        retire_ready_i = 1'b1;
        repeat (WIN_CYCLES) @(negedge clk);
        halt_i    = 1'b0;
        halt_done = 1'b1;
      end else if (!pause_done && (retire_count >= PAUSE_AT)) begin
        pause_i        = 1'b1;
        retire_ready_i = 1'b1;
        repeat (WIN_CYCLES) @(negedge clk);
        pause_i    = 1'b0;
        pause_done = 1'b1;
      end else begin
        // Roughly one cycle in four is back-pressured
        rng            = xorshift32(rng);
        retire_ready_i = (rng[1:0] != 2'b00);
      end
    end

    if (halt_done && pause_done) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Run ended before the halt and pause windows were applied");
      $display("TEST RESULT: FAIL");
      $fatal(1, "windows not exercised");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired, retirements stopped after %0d of %0d", retire_count, TARGET);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* rv_pipe_top.f */
verilog/rv_pipe_pkg.sv
verilog/pipe_ctrl.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/exec_stage.sv
verilog/rv_pipe_top.sv
bench/rv_pipe_tb.sv
